/* build.sh */
#!/bin/sh
# Compiles and runs the tiny_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f tiny_core.f --top-module core_tb -o core_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* common/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width.
`define CORE_DATA_W 32

// register select width.
`define CORE_REG_SEL_W 4

// number of general purpose registers.
`define CORE_REG_COUNT 16

// immediate field, sign-extended to the datapath width.
`define CORE_IMM_W 16

`endif

/* common/core_pkg.sv */
`default_nettype none

`include "core_params.svh"

package core_pkg;

	// ############################################################
	// encodings
	// ############################################################

	typedef enum logic [4:0] {
		alu_add,
		alu_addc,
		alu_sub,
		alu_subc,
		alu_lsl,
		alu_lsr,
		alu_and,
		alu_xor,
		alu_bic,
		alu_bst,
		alu_or,
		alu_mov,
		alu_cmp,
		alu_orlo,
		alu_asr,
		alu_pass
	} alu_op_e;

	typedef enum logic [2:0] {
		br_never  = 3'd0,
		br_ne     = 3'd1,
		br_eq     = 3'd2,
		br_cc     = 3'd3,
		br_cs     = 3'd4,
		br_always = 3'd7
	} branch_cond_e;

	typedef enum logic [1:0] {
		cls_alu    = 2'd0,
		cls_branch = 2'd1,
		cls_mem    = 2'd2,
		cls_call   = 2'd3
	} instr_class_e;

	typedef enum logic [1:0] {
		mw_byte = 2'd0,
		mw_half = 2'd1,
		mw_word = 2'd2
	} mem_width_e;

	// first alu operand source.
	typedef enum logic [1:0] {
		op1_ra = 2'd0,
		op1_rb = 2'd1,
		op1_pc = 2'd2
	} op1_sel_e;

	// ############################################################
	// bundles between stages
	// ############################################################

	typedef struct packed {
		alu_op_e                     alu_opc;
		op1_sel_e                    op1_sel;
		logic                        op2_rb;
		logic [`CORE_DATA_W-1:0]     imm32;
		logic [`CORE_REG_SEL_W-1:0]  rd_sel;
		logic                        update_rd;
		logic                        mem_load;
		logic                        mem_store;
		mem_width_e                  mem_width;
		branch_cond_e                branch_condition;
		instr_class_e                instr_class;
		logic                        is_call;
		logic                        update_flags;
	} exec_ctrl_t;

	typedef struct packed {
		logic                        wr_en;
		logic [`CORE_REG_SEL_W-1:0]  rd_sel;
		logic [`CORE_DATA_W-1:0]     wr_val;
	} wb_t;

	typedef struct packed {
		logic                        load;
		logic                        store;
		mem_width_e                  width;
		logic [`CORE_DATA_W-1:0]     addr;
		logic [`CORE_DATA_W-1:0]     data;
	} mem_req_t;

endpackage

`default_nettype wire

/* design/core_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     instr_valid,
	input  logic [31:0]              instr,
	input  logic [`CORE_DATA_W-1:0]  pc,
	output core_pkg::wb_t            wb,
	output core_pkg::mem_req_t       mem_req,
	output logic                     branch_taken,
	output logic [`CORE_DATA_W-1:0]  branch_target,
	output logic                     stall_clear
);
	import core_pkg::*;

	logic [`CORE_REG_SEL_W-1:0]  ra_sel;
	logic [`CORE_REG_SEL_W-1:0]  rb_sel;
	logic [`CORE_DATA_W-1:0]     ra_val;
	logic [`CORE_DATA_W-1:0]     rb_val;
	logic [`CORE_DATA_W-1:0]     pc_plus_4;
	exec_ctrl_t                  ctrl;

	instr_decoder i_decoder (
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.ra_sel      (ra_sel),
		.rb_sel      (rb_sel),
		.ctrl        (ctrl),
		.pc_plus_4   (pc_plus_4)
	);

	// write-back loops straight into the write port.
	register_file i_regs (
		.clk    (clk),
		.reset  (reset),
		.ra_sel (ra_sel),
		.rb_sel (rb_sel),
		.ra_val (ra_val),
		.rb_val (rb_val),
		.wb     (wb)
	);

	exec_unit i_exec (
		.clk           (clk),
		.reset         (reset),
		.ctrl          (ctrl),
		.ra_val        (ra_val),
		.rb_val        (rb_val),
		.pc_plus_4     (pc_plus_4),
		.wb            (wb),
		.mem_req       (mem_req),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.stall_clear   (stall_clear)
	);

endmodule

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module instr_decoder (
	input  logic                        instr_valid,
	input  logic [31:0]                 instr,
	input  logic [`CORE_DATA_W-1:0]     pc,
	output logic [`CORE_REG_SEL_W-1:0]  ra_sel,
	output logic [`CORE_REG_SEL_W-1:0]  rb_sel,
	output core_pkg::exec_ctrl_t        ctrl,
	output logic [`CORE_DATA_W-1:0]     pc_plus_4
);
	import core_pkg::*;

	instr_class_e                cls;
	alu_op_e                     opc;
	logic [`CORE_REG_SEL_W-1:0]  rd;
	logic [`CORE_REG_SEL_W-1:0]  rb;
	logic [`CORE_IMM_W-1:0]      imm;
	logic [`CORE_DATA_W-1:0]     imm32;
	logic                        is_store;

	// ############################################################
	// field split
	// ############################################################

	assign cls      = instr_class_e'(instr[31:30]);
	assign opc      = alu_op_e'(instr[29:25]);
	assign rd       = instr[23:20];
	assign ra_sel   = instr[19:16];
	assign rb       = instr[15:12];
	assign imm      = instr[`CORE_IMM_W-1:0];
	assign is_store = instr[29];

	assign imm32 = {{(`CORE_DATA_W - `CORE_IMM_W){imm[`CORE_IMM_W-1]}}, imm};

	assign pc_plus_4 = pc + `CORE_DATA_W'd4;

	// store data comes out of read port b.
	assign rb_sel = (cls == cls_mem && is_store) ? rd : rb;

	// ############################################################
	// control word
	// ############################################################

	always_comb begin
		ctrl.alu_opc          = opc;
		ctrl.op1_sel          = op1_ra;
		ctrl.op2_rb           = ~instr[24];
		ctrl.imm32            = imm32;
		ctrl.rd_sel           = rd;
		ctrl.update_rd        = 1'b0;
		ctrl.mem_load         = 1'b0;
		ctrl.mem_store        = 1'b0;
		ctrl.mem_width        = mem_width_e'(instr[26:25]);
		ctrl.branch_condition = br_never;
		ctrl.instr_class      = cls;
		ctrl.is_call          = 1'b0;
		ctrl.update_flags     = 1'b0;

		case (cls)
		cls_alu: begin
			ctrl.update_rd    = (opc != alu_cmp);
			ctrl.update_flags = opc inside {alu_add, alu_addc, alu_sub, alu_subc, alu_cmp};
		end
		cls_branch: begin
			// target is pc + 4 + imm.
			ctrl.alu_opc          = alu_add;
			ctrl.op1_sel          = op1_pc;
			ctrl.op2_rb           = 1'b0;
			ctrl.branch_condition = branch_cond_e'(instr[27:25]);
		end
		cls_mem: begin
			// address is ra + imm.
			ctrl.alu_opc   = alu_add;
			ctrl.op2_rb    = 1'b0;
			ctrl.mem_store = is_store;
			ctrl.mem_load  = ~is_store;
		end
		cls_call: begin
			ctrl.alu_opc   = alu_pass;
			ctrl.is_call   = 1'b1;
			ctrl.update_rd = 1'b1;
		end
		default: ;
		endcase

		// bubble.
		if (!instr_valid) begin
			ctrl.update_rd        = 1'b0;
			ctrl.mem_load         = 1'b0;
			ctrl.mem_store        = 1'b0;
			ctrl.branch_condition = br_never;
			ctrl.instr_class      = cls_alu;
			ctrl.is_call          = 1'b0;
			ctrl.update_flags     = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module register_file (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`CORE_REG_SEL_W-1:0]  ra_sel,
	input  logic [`CORE_REG_SEL_W-1:0]  rb_sel,
	output logic [`CORE_DATA_W-1:0]     ra_val,
	output logic [`CORE_DATA_W-1:0]     rb_val,
	input  core_pkg::wb_t               wb
);

	logic [`CORE_DATA_W-1:0] regs [`CORE_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wr_en) begin
			regs[wb.rd_sel] <= wb.wr_val;
		end
	end

	// same-cycle write bypass.
	assign ra_val = (wb.wr_en && wb.rd_sel == ra_sel) ? wb.wr_val : regs[ra_sel];
	assign rb_val = (wb.wr_en && wb.rd_sel == rb_sel) ? wb.wr_val : regs[rb_sel];

endmodule

`default_nettype wire

/* dv/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module core_tb;
	import core_pkg::*;

	typedef struct packed {
		logic         valid;
		logic [31:0]  instr;
		logic [31:0]  pc;
		logic         wr_en;
		logic [3:0]   rd;
		logic         chk_val;
		logic [31:0]  wr_val;
		logic         load;
		logic         store;
		logic         chk_mem;
		logic [1:0]   width;
		logic [31:0]  addr;
		logic         chk_data;
		logic [31:0]  data;
		logic         taken;
		logic         chk_target;
		logic [31:0]  target;
		logic         stall;
	} row_t;

	logic                     clk = 1'b0;
	logic                     reset;
	logic                     instr_valid;
	logic [31:0]              instr;
	logic [`CORE_DATA_W-1:0]  pc;
	wb_t                      wb;
	mem_req_t                 mem_req;
	logic                     branch_taken;
	logic [`CORE_DATA_W-1:0]  branch_target;
	logic                     stall_clear;

	row_t         tbl[$];
	logic [31:0]  next_pc = 32'h0000_0100;
	integer       seed = 32'h713d;
	int           errors = 0;
	int           checks = 0;
	int           cycles = 0;
	int           max_cycles = 0;

	core_top i_dut (
		.clk           (clk),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.pc            (pc),
		.wb            (wb),
		.mem_req       (mem_req),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.stall_clear   (stall_clear)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > max_cycles) begin
			$display("timeout: run went past %0d cycles", max_cycles);
			$display("Test failed");
			$finish;
		end
	end

	// ############################################################
	// table builders
	// ############################################################

	function automatic logic [31:0] make_instr(input logic [1:0] cls, input logic [4:0] opc,
		input logic use_imm, input logic [3:0] rd, input logic [3:0] ra, input logic [15:0] low);
		return {cls, opc, use_imm, rd, ra, low};
	endfunction

	function automatic logic [31:0] sext(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic add_idle();
		row_t r;
		r = '0;
		tbl.push_back(r);
	endtask

	task automatic add_alu(input logic [4:0] opc, input logic use_imm, input logic [3:0] rd,
		input logic [3:0] ra, input logic [15:0] low, input logic [31:0] result);
		row_t r;
		r = '0;
		r.valid = 1'b1;
		r.instr = make_instr(2'd0, opc, use_imm, rd, ra, low);
		r.pc = next_pc;
		// compare only moves the flags.
		r.wr_en = (opc != alu_cmp);
		r.rd = rd;
		r.chk_val = r.wr_en;
		r.wr_val = result;
		tbl.push_back(r);
		next_pc = next_pc + 32'd4;
	endtask

	task automatic add_branch(input logic [2:0] cond, input logic [15:0] imm, input logic taken);
		row_t r;
		r = '0;
		r.valid = 1'b1;
		r.instr = make_instr(2'd1, {2'b00, cond}, 1'b1, 4'h0, 4'h0, imm);
		r.pc = next_pc;
		r.taken = taken;
		r.chk_target = 1'b1;
		r.target = next_pc + 32'd4 + sext(imm);
		r.stall = 1'b1;
		tbl.push_back(r);
		next_pc = next_pc + 32'd4;
	endtask

	task automatic add_mem(input logic store, input logic [1:0] width, input logic [3:0] rd,
		input logic [3:0] ra, input logic [15:0] imm, input logic [31:0] addr,
		input logic [31:0] data);
		row_t r;
		r = '0;
		r.valid = 1'b1;
		r.instr = make_instr(2'd2, {store, 2'b00, width}, 1'b1, rd, ra, imm);
		r.pc = next_pc;
		r.load = ~store;
		r.store = store;
		r.chk_mem = 1'b1;
		r.width = width;
		r.addr = addr;
		r.chk_data = store;
		r.data = data;
		// a store passes its immediate through the write-back value.
		r.chk_val = store;
		r.wr_val = sext(imm);
		tbl.push_back(r);
		next_pc = next_pc + 32'd4;
	endtask

	task automatic add_call(input logic [3:0] rd, input logic [3:0] ra, input logic [31:0] target);
		row_t r;
		r = '0;
		r.valid = 1'b1;
		r.instr = make_instr(2'd3, 5'd0, 1'b0, rd, ra, 16'h0000);
		r.pc = next_pc;
		r.wr_en = 1'b1;
		r.rd = rd;
		r.chk_val = 1'b1;
		r.wr_val = next_pc + 32'd4;
		r.taken = 1'b1;
		r.chk_target = 1'b1;
		r.target = target;
		r.stall = 1'b1;
		tbl.push_back(r);
		next_pc = next_pc + 32'd4;
	endtask

	task automatic build_table();
		add_idle();
		add_idle();
		add_alu(alu_mov, 1'b1, 4'd1, 4'd0, 16'h1234, 32'h0000_1234);
		add_alu(alu_mov, 1'b1, 4'd2, 4'd0, 16'hfff0, 32'hffff_fff0);
		// add overflows into C for the addc and subc after it.
		add_alu(alu_add, 1'b0, 4'd3, 4'd1, 16'h2000, 32'h0000_1224);
		add_alu(alu_addc, 1'b1, 4'd4, 4'd2, 16'h000f, 32'h0000_0000);
		add_alu(alu_subc, 1'b1, 4'd5, 4'd1, 16'h0004, 32'h0000_1231);
		add_alu(alu_sub, 1'b0, 4'd6, 4'd1, 16'h5000, 32'h0000_0003);
		add_alu(alu_cmp, 1'b1, 4'd0, 4'd1, 16'h1234, 32'h0000_0000);
		// flags now Z=1 C=0.
		add_branch(br_eq, 16'h0010, 1'b1);
		add_branch(br_ne, 16'hfff8, 1'b0);
		add_branch(br_cc, 16'h0100, 1'b1);
		add_branch(br_cs, 16'h0020, 1'b0);
		add_branch(br_never, 16'h0004, 1'b0);
		add_branch(br_always, 16'hff00, 1'b1);
		// flags now Z=0 C=1.
		add_alu(alu_add, 1'b1, 4'd7, 4'd2, 16'h0010, 32'h0000_0000);
		add_branch(br_cs, 16'h0040, 1'b1);
		add_branch(br_cc, 16'h0008, 1'b0);
		add_branch(br_ne, 16'hfffc, 1'b1);
		add_branch(br_eq, 16'h0030, 1'b0);
		add_alu(alu_lsl, 1'b1, 4'd8, 4'd1, 16'h0004, 32'h0001_2340);
		add_alu(alu_lsr, 1'b1, 4'd9, 4'd8, 16'h0008, 32'h0000_0123);
		add_alu(alu_mov, 1'b1, 4'd10, 4'd0, 16'h8000, 32'hffff_8000);
		add_alu(alu_asr, 1'b1, 4'd11, 4'd10, 16'h0004, 32'hffff_f800);
		add_alu(alu_and, 1'b0, 4'd12, 4'd2, 16'h1000, 32'h0000_1230);
		add_alu(alu_or, 1'b1, 4'd13, 4'd1, 16'h0f00, 32'h0000_1f34);
		add_alu(alu_xor, 1'b0, 4'd14, 4'd13, 16'h1000, 32'h0000_0d00);
		add_alu(alu_bic, 1'b1, 4'd15, 4'd2, 16'h0004, 32'hffff_ffe0);
		add_alu(alu_bst, 1'b1, 4'd3, 4'd1, 16'h001f, 32'h8000_1234);
		add_alu(alu_orlo, 1'b1, 4'd4, 4'd1, 16'h8001, 32'h0000_9235);
		add_alu(alu_cmp, 1'b0, 4'd0, 4'd1, 16'h6000, 32'h0000_0000);
		add_idle();
		add_mem(1'b1, mw_word, 4'd1, 4'd2, 16'h0020, 32'h0000_0010, 32'h0000_1234);
		add_mem(1'b0, mw_half, 4'd5, 4'd1, 16'hfffe, 32'h0000_1232, 32'h0000_0000);
		add_mem(1'b1, mw_byte, 4'd6, 4'd1, 16'h0004, 32'h0000_1238, 32'h0000_0003);
		add_call(4'd7, 4'd9, 32'h0000_0123);
		add_idle();
		add_idle();
	endtask

	// ############################################################
	// drive and check
	// ############################################################

	task automatic drive_row(input row_t r);
		instr_valid = r.valid;
		pc = r.pc;
		if (r.valid) begin
			instr = r.instr;
		end else begin
			instr = $random(seed);
		end
	endtask

	task automatic compare_value(input string tag, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error: %s %s = %h, expected %h", tag, name, got, exp);
		end
	endtask

	task automatic check_row(input string tag, input row_t r);
		compare_value(tag, "wb.wr_en", 32'(wb.wr_en), 32'(r.wr_en));
		compare_value(tag, "mem_req.load", 32'(mem_req.load), 32'(r.load));
		compare_value(tag, "mem_req.store", 32'(mem_req.store), 32'(r.store));
		compare_value(tag, "branch_taken", 32'(branch_taken), 32'(r.taken));
		compare_value(tag, "stall_clear", 32'(stall_clear), 32'(r.stall));
		if (r.wr_en) begin
			compare_value(tag, "wb.rd_sel", 32'(wb.rd_sel), 32'(r.rd));
		end
		if (r.chk_val) begin
			compare_value(tag, "wb.wr_val", wb.wr_val, r.wr_val);
		end
		if (r.chk_mem) begin
			compare_value(tag, "mem_req.width", 32'(mem_req.width), 32'(r.width));
			compare_value(tag, "mem_req.addr", mem_req.addr, r.addr);
		end
		if (r.chk_data) begin
			compare_value(tag, "mem_req.data", mem_req.data, r.data);
		end
		if (r.chk_target) begin
			compare_value(tag, "branch_target", branch_target, r.target);
		end
	endtask

	initial begin
		row_t idle;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		idle = '0;
		build_table();
		max_cycles = 4 + tbl.size() + 10;

		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		check_row("after reset", idle);
		drive_row(tbl[0]);

		// each row's results show up one edge after it is driven.
		for (int i = 1; i <= tbl.size(); i++) begin
			@(posedge clk);
			#2;
			check_row($sformatf("row %0d", i - 1), tbl[i - 1]);
			if (i < tbl.size()) begin
				drive_row(tbl[i]);
			end else begin
				drive_row(idle);
			end
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* exec/exec_alu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module exec_alu (
	input  core_pkg::exec_ctrl_t     ctrl,
	input  logic [`CORE_DATA_W-1:0]  ra_val,
	input  logic [`CORE_DATA_W-1:0]  rb_val,
	input  logic [`CORE_DATA_W-1:0]  pc_plus_4,
	input  logic                     c_flag,
	output logic [`CORE_DATA_W-1:0]  alu_q,
	output logic                     alu_c,
	output logic                     alu_z,
	output logic [`CORE_DATA_W-1:0]  op2
);
	import core_pkg::*;

	logic [`CORE_DATA_W-1:0]  op1;
	logic [4:0]               shamt;
	logic [`CORE_DATA_W-1:0]  bit_mask;
	logic [`CORE_DATA_W:0]    carry_in;

	// ############################################################
	// operands
	// ############################################################

	always_comb begin
		case (ctrl.op1_sel)
		op1_ra:  op1 = ra_val;
		op1_rb:  op1 = rb_val;
		default: op1 = pc_plus_4;
		endcase
	end

	assign op2      = ctrl.op2_rb ? rb_val : ctrl.imm32;
	assign shamt    = op2[4:0];
	assign bit_mask = `CORE_DATA_W'd1 << shamt;
	assign carry_in = {{`CORE_DATA_W{1'b0}}, c_flag};

	assign alu_z = (op1 == op2);

	// ############################################################
	// operations
	// ############################################################

	always_comb begin
		alu_c = 1'b0;
		alu_q = '0;

		case (ctrl.alu_opc)
		alu_add:  {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		alu_addc: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + carry_in;
		alu_sub:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		alu_subc: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} + carry_in;
		alu_lsl:  {alu_c, alu_q} = {1'b0, op1} << shamt;
		alu_lsr:  alu_q = op1 >> shamt;
		alu_and:  alu_q = op1 & op2;
		alu_xor:  alu_q = op1 ^ op2;
		alu_bic:  alu_q = op1 & ~bit_mask;
		alu_bst:  alu_q = op1 | bit_mask;
		alu_or:   alu_q = op1 | op2;
		alu_mov:  alu_q = op2;
		// compare is a subtract that only feeds the flags.
		alu_cmp:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		alu_orlo: alu_q = op1 | {{(`CORE_DATA_W - `CORE_IMM_W){1'b0}}, op2[`CORE_IMM_W-1:0]};
		alu_asr:  alu_q = $signed(op1) >>> shamt;
		alu_pass: alu_q = op1;
		default:  alu_q = '0;
		endcase
	end

endmodule

`default_nettype wire

/* exec/exec_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module exec_unit (
	input  logic                     clk,
	input  logic                     reset,
	input  core_pkg::exec_ctrl_t     ctrl,
	input  logic [`CORE_DATA_W-1:0]  ra_val,
	input  logic [`CORE_DATA_W-1:0]  rb_val,
	input  logic [`CORE_DATA_W-1:0]  pc_plus_4,
	output core_pkg::wb_t            wb,
	output core_pkg::mem_req_t       mem_req,
	output logic                     branch_taken,
	output logic [`CORE_DATA_W-1:0]  branch_target,
	output logic                     stall_clear
);
	import core_pkg::*;

	logic [`CORE_DATA_W-1:0]  alu_q;
	logic                     alu_c;
	logic                     alu_z;
	logic [`CORE_DATA_W-1:0]  op2;
	logic                     z_flag;
	logic                     c_flag;
	logic                     cond_met;
	logic                     is_branch;

	exec_alu i_alu (
		.ctrl      (ctrl),
		.ra_val    (ra_val),
		.rb_val    (rb_val),
		.pc_plus_4 (pc_plus_4),
		.c_flag    (c_flag),
		.alu_q     (alu_q),
		.alu_c     (alu_c),
		.alu_z     (alu_z),
		.op2       (op2)
	);

	// ############################################################
	// branch condition
	// ############################################################

	always_comb begin
		case (ctrl.branch_condition)
		br_always: cond_met = 1'b1;
		br_ne:     cond_met = ~z_flag;
		br_eq:     cond_met = z_flag;
		br_cc:     cond_met = ~c_flag;
		br_cs:     cond_met = c_flag;
		default:   cond_met = 1'b0;
		endcase
	end

	assign is_branch = (ctrl.instr_class == cls_branch);

	// ############################################################
	// result registers
	// ############################################################

	always_ff @(posedge clk) begin
		if (ctrl.update_flags) begin
			z_flag <= alu_z;
			c_flag <= alu_c;
		end

		wb.wr_en  <= ctrl.update_rd;
		wb.rd_sel <= ctrl.rd_sel;
		wb.wr_val <= ctrl.is_call ? pc_plus_4 :
			ctrl.mem_store ? op2 : alu_q;

		mem_req.load  <= ctrl.mem_load;
		mem_req.store <= ctrl.mem_store;
		if (ctrl.mem_load || ctrl.mem_store) begin
			mem_req.width <= ctrl.mem_width;
			mem_req.addr  <= alu_q;
		end
		// rb_val carries rd on a store.
		if (ctrl.mem_store) begin
			mem_req.data <= rb_val;
		end

		branch_taken  <= ctrl.is_call || (is_branch && cond_met);
		branch_target <= alu_q;
		stall_clear   <= ctrl.is_call || is_branch;

		if (reset) begin
			z_flag        <= 1'b0;
			c_flag        <= 1'b0;
			wb.wr_en      <= 1'b0;
			mem_req.load  <= 1'b0;
			mem_req.store <= 1'b0;
			branch_taken  <= 1'b0;
			stall_clear   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* tiny_core.f */
+incdir+common
common/core_pkg.sv
design/instr_decoder.sv
design/register_file.sv
exec/exec_alu.sv
exec/exec_unit.sv
design/core_top.sv
dv/core_tb.sv
